// File: verilog/rv_lsu_pkg.sv
package rv_lsu_pkg;

	// load funct3 encodings
	localparam logic [2:0] load_lb  = 3'b000;
	localparam logic [2:0] load_lh  = 3'b001;
	localparam logic [2:0] load_lw  = 3'b010;
	localparam logic [2:0] load_lbu = 3'b100;
	localparam logic [2:0] load_lhu = 3'b101;

	// store funct3 encodings
	localparam logic [2:0] store_sb = 3'b000;
	localparam logic [2:0] store_sh = 3'b001;
	localparam logic [2:0] store_sw = 3'b010;

	typedef enum logic [1:0] {
		cause_none             = 2'd0,
		cause_misaligned_load  = 2'd1,
		cause_misaligned_store = 2'd2,
		cause_bus_error        = 2'd3
	} fault_cause_t;

	// one memory word seen as byte lanes or as half lanes
	typedef union packed {
		logic [3:0][7:0]  bytes;   // bytes[0] is the lowest address
		logic [1:0][15:0] halves;  // halves[1] is the upper half
	} mem_word_u;

	// access controller state codes
	localparam logic [2:0] st_idle    = 3'd0;
	localparam logic [2:0] st_decode  = 3'd1;  // lane outputs settle from the request regs
	localparam logic [2:0] st_access  = 3'd2;  // address and write data channels
	localparam logic [2:0] st_wait    = 3'd3;  // waiting on R or B
	localparam logic [2:0] st_respond = 3'd4;

endpackage

// File: verilog/axi_lite_pkg.sv
package axi_lite_pkg;

	localparam int addr_width = 32;
	localparam int data_width = 32;

	// xRESP encodings
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_exokay = 2'b01;
	localparam logic [1:0] resp_slverr = 2'b10;
	localparam logic [1:0] resp_decerr = 2'b11;

endpackage

// File: verilog/byte_lane_logic.sv
`timescale 1ns/1ps

module byte_lane_logic (
	input  logic        mem_read,      // a load is in flight
	input  logic        mem_write,     // a store is in flight
	input  logic [2:0]  funct3,
	input  logic [1:0]  addr_low,      // byte offset inside the word
	input  logic [31:0] store_data,    // rs2 value from the core
	input  logic [31:0] load_word,     // full word returned by the bus
	output logic [31:0] load_result,   // extended value for the register file
	output logic [31:0] store_word,    // replicated data for wdata
	output logic [3:0]  write_strobe,
	output logic        misaligned
);

	rv_lsu_pkg::mem_word_u rd_word;
	rv_lsu_pkg::mem_word_u wr_word;
	logic [7:0]            sel_byte;
	logic [15:0]           sel_half;

	assign rd_word  = load_word;
	assign sel_byte = rd_word.bytes[addr_low];
	assign sel_half = rd_word.halves[addr_low[1]];  // bit 0 only matters for the fault

	always_comb begin
		load_result  = '0;
		wr_word      = '0;
		write_strobe = '0;
		misaligned   = 1'b0;
		if (mem_read) begin
			case (funct3)
				rv_lsu_pkg::load_lb: begin
					load_result = {{24{sel_byte[7]}}, sel_byte};
				end
				rv_lsu_pkg::load_lbu: begin
					load_result = {24'b0, sel_byte};
				end
				rv_lsu_pkg::load_lh: begin
					misaligned = addr_low[0];
					if (!addr_low[0]) begin
						load_result = {{16{sel_half[15]}}, sel_half};
					end
				end
				rv_lsu_pkg::load_lhu: begin
					misaligned = addr_low[0];
					if (!addr_low[0]) begin
						load_result = {16'b0, sel_half};
					end
				end
				rv_lsu_pkg::load_lw: begin
					misaligned = (addr_low != 2'b00);
					if (addr_low == 2'b00) begin
						load_result = rd_word;
					end
				end
				default: begin
					load_result = '0;  // unknown funct3 reads as nothing
				end
			endcase
		end else if (mem_write) begin
			case (funct3)
				rv_lsu_pkg::store_sb: begin
					wr_word.bytes = {4{store_data[7:0]}};
					write_strobe  = 4'b0001 << addr_low;
				end
				rv_lsu_pkg::store_sh: begin
					wr_word.halves = {2{store_data[15:0]}};
					misaligned     = addr_low[0];
					if (!addr_low[0]) begin
						write_strobe = addr_low[1] ? 4'b1100 : 4'b0011;
					end
				end
				rv_lsu_pkg::store_sw: begin
					wr_word    = store_data;
					misaligned = (addr_low != 2'b00);
					if (addr_low == 2'b00) begin
						write_strobe = 4'b1111;
					end
				end
				default: begin
					write_strobe = '0;
				end
			endcase
		end
	end

	assign store_word = wr_word;

endmodule

// File: verilog/lsu_fault_status.sv
`timescale 1ns/1ps

module lsu_fault_status (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     fault_set,      // one-cycle pulse from the access controller
	input  rv_lsu_pkg::fault_cause_t fault_cause,
	input  logic [31:0]              fault_addr,
	input  logic                     fault_clear,    // core acknowledges the fault
	output logic                     fault_pending,
	output rv_lsu_pkg::fault_cause_t fault_cause_q,
	output logic [31:0]              fault_addr_q,
	output logic                     accept_enable
);

	logic capture;

	// only the first fault is kept, a set in the clear cycle still lands
	assign capture = fault_set && (!fault_pending || fault_clear);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fault_pending <= 1'b0;
			fault_cause_q <= rv_lsu_pkg::cause_none;
		end else if (capture) begin
			fault_pending <= 1'b1;
			fault_cause_q <= fault_cause;
		end else if (fault_clear) begin
			fault_pending <= 1'b0;
			fault_cause_q <= rv_lsu_pkg::cause_none;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			fault_addr_q <= fault_addr;  // full request address, low bits kept
		end
	end

	assign accept_enable = !fault_pending;  // requests wait until the core clears

endmodule

// File: verilog/lsu_axi_master.sv
`timescale 1ns/1ps

module lsu_axi_master (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 req_valid,
	output logic                                 req_ready,
	input  logic                                 req_write,
	input  logic [2:0]                           req_funct3,
	input  logic [31:0]                          req_addr,
	input  logic [31:0]                          req_wdata,
	output logic                                 resp_valid,
	output logic [31:0]                          resp_rdata,
	output logic                                 resp_fault,
	input  logic                                 accept_enable,
	output logic                                 lane_read,
	output logic                                 lane_write,
	output logic [2:0]                           lane_funct3,
	output logic [1:0]                           lane_addr_low,
	output logic [31:0]                          lane_store_data,
	output logic [31:0]                          lane_load_word,
	input  logic [3:0]                           write_strobe,
	input  logic [31:0]                          store_word,
	input  logic [31:0]                          load_result,
	input  logic                                 misaligned,
	output logic                                 fault_set,
	output rv_lsu_pkg::fault_cause_t             fault_cause,
	output logic [31:0]                          fault_addr,
	output logic [axi_lite_pkg::addr_width-1:0]  awaddr,
	output logic [2:0]                           awprot,
	output logic                                 awvalid,
	input  logic                                 awready,
	output logic [axi_lite_pkg::data_width-1:0]  wdata,
	output logic [axi_lite_pkg::data_width/8-1:0] wstrb,
	output logic                                 wvalid,
	input  logic                                 wready,
	input  logic [1:0]                           bresp,
	input  logic                                 bvalid,
	output logic                                 bready,
	output logic [axi_lite_pkg::addr_width-1:0]  araddr,
	output logic [2:0]                           arprot,
	output logic                                 arvalid,
	input  logic                                 arready,
	input  logic [axi_lite_pkg::data_width-1:0]  rdata,
	input  logic [1:0]                           rresp,
	input  logic                                 rvalid,
	output logic                                 rready
);

	logic [2:0]               state;
	logic                     ready_q;       // high while idle, low in the first cycle after reset
	logic                     req_write_q;
	logic [2:0]               req_funct3_q;
	logic [31:0]              req_addr_q;
	logic [31:0]              req_wdata_q;
	logic [31:0]              load_word_q;   // read data held for lane extraction
	logic                     resp_fault_q;
	rv_lsu_pkg::fault_cause_t cause_q;
	logic                     accept;
	logic                     aw_pending;
	logic                     w_pending;

	function automatic logic resp_is_error(input logic [1:0] resp);
		case (resp)
			axi_lite_pkg::resp_okay, axi_lite_pkg::resp_exokay: resp_is_error = 1'b0;
			axi_lite_pkg::resp_slverr, axi_lite_pkg::resp_decerr: resp_is_error = 1'b1;
			default: resp_is_error = 1'b1;
		endcase
	endfunction

	assign accept     = req_valid && req_ready;
	assign aw_pending = awvalid && !awready;  // write address still waiting
	assign w_pending  = wvalid && !wready;    // write data still waiting

	always_ff @(posedge clk) begin
		if (accept) begin
			req_write_q  <= req_write;
			req_funct3_q <= req_funct3;
			req_addr_q   <= req_addr;
			req_wdata_q  <= req_wdata;
		end
		if (rvalid && rready) begin
			load_word_q <= rdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= rv_lsu_pkg::st_idle;
			ready_q      <= 1'b0;
			arvalid      <= 1'b0;
			awvalid      <= 1'b0;
			wvalid       <= 1'b0;
			rready       <= 1'b0;
			bready       <= 1'b0;
			resp_fault_q <= 1'b0;
			cause_q      <= rv_lsu_pkg::cause_none;
		end else begin
			case (state)
				rv_lsu_pkg::st_idle: begin
					ready_q <= 1'b1;
					if (accept) begin
						ready_q      <= 1'b0;
						resp_fault_q <= 1'b0;
						cause_q      <= rv_lsu_pkg::cause_none;
						state        <= rv_lsu_pkg::st_decode;
					end
				end
				rv_lsu_pkg::st_decode: begin
					if (misaligned) begin  // answer at once with no bus access
						resp_fault_q <= 1'b1;
						cause_q      <= req_write_q ? rv_lsu_pkg::cause_misaligned_store
						                            : rv_lsu_pkg::cause_misaligned_load;
						state        <= rv_lsu_pkg::st_respond;
					end else if (req_write_q) begin
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
						state   <= rv_lsu_pkg::st_access;
					end else begin
						arvalid <= 1'b1;
						state   <= rv_lsu_pkg::st_access;
					end
				end
				rv_lsu_pkg::st_access: begin
					if (req_write_q) begin
						awvalid <= aw_pending;
						wvalid  <= w_pending;
						if (!aw_pending && !w_pending) begin
							bready <= 1'b1;
							state  <= rv_lsu_pkg::st_wait;
						end
					end else if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= rv_lsu_pkg::st_wait;
					end
				end
				rv_lsu_pkg::st_wait: begin
					if (rvalid && rready) begin
						rready       <= 1'b0;
						resp_fault_q <= resp_is_error(rresp);
						cause_q      <= resp_is_error(rresp) ? rv_lsu_pkg::cause_bus_error
						                                     : rv_lsu_pkg::cause_none;
						state        <= rv_lsu_pkg::st_respond;
					end
					if (bvalid && bready) begin
						bready       <= 1'b0;
						resp_fault_q <= resp_is_error(bresp);
						cause_q      <= resp_is_error(bresp) ? rv_lsu_pkg::cause_bus_error
						                                     : rv_lsu_pkg::cause_none;
						state        <= rv_lsu_pkg::st_respond;
					end
				end
				rv_lsu_pkg::st_respond: begin
					ready_q <= 1'b1;
					state   <= rv_lsu_pkg::st_idle;
				end
				default: begin
					state <= rv_lsu_pkg::st_idle;
				end
			endcase
		end
	end

	assign req_ready  = ready_q && accept_enable;
	assign resp_valid = (state == rv_lsu_pkg::st_respond);
	assign resp_fault = resp_valid && resp_fault_q;
	assign resp_rdata = (resp_valid && !req_write_q && !resp_fault_q) ? load_result : '0;

	// status block samples these during the response cycle
	assign fault_set   = resp_fault;
	assign fault_cause = cause_q;
	assign fault_addr  = req_addr_q;

	assign lane_read       = (state != rv_lsu_pkg::st_idle) && !req_write_q;
	assign lane_write      = (state != rv_lsu_pkg::st_idle) && req_write_q;
	assign lane_funct3     = req_funct3_q;
	assign lane_addr_low   = req_addr_q[1:0];
	assign lane_store_data = req_wdata_q;
	assign lane_load_word  = load_word_q;

	assign awaddr = {req_addr_q[31:2], 2'b00};  // word aligned with lanes picked by wstrb
	assign araddr = {req_addr_q[31:2], 2'b00};
	assign awprot = 3'b000;
	assign arprot = 3'b000;
	assign wdata  = store_word;
	assign wstrb  = write_strobe;

endmodule

// File: verilog/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 req_valid,
	output logic                                 req_ready,
	input  logic                                 req_write,
	input  logic [2:0]                           req_funct3,
	input  logic [31:0]                          req_addr,
	input  logic [31:0]                          req_wdata,
	output logic                                 resp_valid,
	output logic [31:0]                          resp_rdata,
	output logic                                 resp_fault,
	input  logic                                 fault_clear,
	output logic                                 fault_pending,
	output rv_lsu_pkg::fault_cause_t             fault_cause,
	output logic [31:0]                          fault_addr,
	output logic [axi_lite_pkg::addr_width-1:0]  awaddr,
	output logic [2:0]                           awprot,
	output logic                                 awvalid,
	input  logic                                 awready,
	output logic [axi_lite_pkg::data_width-1:0]  wdata,
	output logic [axi_lite_pkg::data_width/8-1:0] wstrb,
	output logic                                 wvalid,
	input  logic                                 wready,
	input  logic [1:0]                           bresp,
	input  logic                                 bvalid,
	output logic                                 bready,
	output logic [axi_lite_pkg::addr_width-1:0]  araddr,
	output logic [2:0]                           arprot,
	output logic                                 arvalid,
	input  logic                                 arready,
	input  logic [axi_lite_pkg::data_width-1:0]  rdata,
	input  logic [1:0]                           rresp,
	input  logic                                 rvalid,
	output logic                                 rready
);

	logic                     lane_read;
	logic                     lane_write;
	logic [2:0]               lane_funct3;
	logic [1:0]               lane_addr_low;
	logic [31:0]              lane_store_data;
	logic [31:0]              lane_load_word;
	logic [31:0]              load_result;
	logic [31:0]              store_word;
	logic [3:0]               write_strobe;
	logic                     misaligned;
	logic                     accept_enable;
	logic                     fault_set;
	rv_lsu_pkg::fault_cause_t set_cause;    // cause of the fault being raised now
	logic [31:0]              set_addr;

	byte_lane_logic lanes_i (
		.mem_read     (lane_read),
		.mem_write    (lane_write),
		.funct3       (lane_funct3),
		.addr_low     (lane_addr_low),
		.store_data   (lane_store_data),
		.load_word    (lane_load_word),
		.load_result  (load_result),
		.store_word   (store_word),
		.write_strobe (write_strobe),
		.misaligned   (misaligned)
	);

	lsu_axi_master master_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.req_valid       (req_valid),
		.req_ready       (req_ready),
		.req_write       (req_write),
		.req_funct3      (req_funct3),
		.req_addr        (req_addr),
		.req_wdata       (req_wdata),
		.resp_valid      (resp_valid),
		.resp_rdata      (resp_rdata),
		.resp_fault      (resp_fault),
		.accept_enable   (accept_enable),
		.lane_read       (lane_read),
		.lane_write      (lane_write),
		.lane_funct3     (lane_funct3),
		.lane_addr_low   (lane_addr_low),
		.lane_store_data (lane_store_data),
		.lane_load_word  (lane_load_word),
		.write_strobe    (write_strobe),
		.store_word      (store_word),
		.load_result     (load_result),
		.misaligned      (misaligned),
		.fault_set       (fault_set),
		.fault_cause     (set_cause),
		.fault_addr      (set_addr),
		.awaddr          (awaddr),
		.awprot          (awprot),
		.awvalid         (awvalid),
		.awready         (awready),
		.wdata           (wdata),
		.wstrb           (wstrb),
		.wvalid          (wvalid),
		.wready          (wready),
		.bresp           (bresp),
		.bvalid          (bvalid),
		.bready          (bready),
		.araddr          (araddr),
		.arprot          (arprot),
		.arvalid         (arvalid),
		.arready         (arready),
		.rdata           (rdata),
		.rresp           (rresp),
		.rvalid          (rvalid),
		.rready          (rready)
	);

	lsu_fault_status status_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.fault_set     (fault_set),
		.fault_cause   (set_cause),
		.fault_addr    (set_addr),
		.fault_clear   (fault_clear),
		.fault_pending (fault_pending),
		.fault_cause_q (fault_cause),
		.fault_addr_q  (fault_addr),
		.accept_enable (accept_enable)
	);

endmodule

// File: dv/lsu_assert.sv
`timescale 1ns/1ps

module lsu_assert (
	input logic        clk,
	input logic        rst_n,
	input logic        req_ready,
	input logic        resp_valid,
	input logic        fault_pending,
	input logic        arvalid,
	input logic        arready,
	input logic [31:0] araddr,
	input logic        awvalid,
	input logic        awready,
	input logic [31:0] awaddr,
	input logic        wvalid,
	input logic        wready,
	input logic [31:0] wdata,
	input logic [3:0]  wstrb
);

	resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |=> !resp_valid)
		else $error("resp_valid stayed high for two cycles");

	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid or araddr changed before arready");

	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid or awaddr changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else $error("wvalid or write data changed before wready");

	strobe_set: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid |-> wstrb != 4'b0000)
		else $error("write data sent with an empty strobe");

	// no request may be taken while a fault waits for the core
	ready_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		fault_pending |-> !req_ready)
		else $error("req_ready high while a fault is pending");

endmodule

bind load_store_unit lsu_assert assert_i (
	.clk           (clk),
	.rst_n         (rst_n),
	.req_ready     (req_ready),
	.resp_valid    (resp_valid),
	.fault_pending (fault_pending),
	.arvalid       (arvalid),
	.arready       (arready),
	.araddr        (araddr),
	.awvalid       (awvalid),
	.awready       (awready),
	.awaddr        (awaddr),
	.wvalid        (wvalid),
	.wready        (wready),
	.wdata         (wdata),
	.wstrb         (wstrb)
);

// File: dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        req_valid;
	logic        req_ready;
	logic        req_write;
	logic [2:0]  req_funct3;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;
	logic        resp_valid;
	logic [31:0] resp_rdata;
	logic        resp_fault;
	logic        fault_clear;
	logic        fault_pending;
	rv_lsu_pkg::fault_cause_t fault_cause;
	logic [31:0] fault_addr;
	logic [31:0] awaddr;
	logic [2:0]  awprot;
	logic        awvalid;
	logic        awready = 1'b0;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready = 1'b0;
	logic [1:0]  bresp = 2'b00;
	logic        bvalid = 1'b0;
	logic        bready;
	logic [31:0] araddr;
	logic [2:0]  arprot;
	logic        arvalid;
	logic        arready = 1'b0;
	logic [31:0] rdata = 32'h0;
	logic [1:0]  rresp = 2'b00;
	logic        rvalid = 1'b0;
	logic        rready;

	integer      seed = 32'h9f93_7da6;
	logic [31:0] mem [0:255];     // memory behind the AXI port
	logic [31:0] shadow [0:255];  // expected memory contents
	logic        exp_fault_q [$];
	logic [31:0] exp_rdata_q [$];
	logic        cmp_fault;
	logic [31:0] cmp_rdata;
	logic [31:0] exp_bus_addr;    // word address expected on AR or AW
	logic [31:0] exp_wdata;       // replicated store word expected on W
	int          bus_count = 0;   // AR plus AW handshakes
	int          bus_before;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          err_base = 0;
	int          rd_delay, aw_delay, w_delay, b_delay, rd_wait, b_wait, bi;
	int          hs_wait;
	logic        aw_done, w_done;
	logic        aw_take, w_take;
	logic [31:0] rd_addr, wr_addr, wr_data, rnd, rnd_addr;
	logic [3:0]  wr_strb;
	logic        r_write;
	logic [2:0]  r_funct3;
	logic [31:0] r_addr;
	event        abort_ev;
	string       abort_reason;

	load_store_unit dut_i (.*);

	always #50 clk = ~clk;

	function automatic void lsu_expect(
		input  logic        write,
		input  logic [2:0]  funct3,
		input  logic [31:0] addr,
		input  logic [31:0] wdata_in,
		input  logic [31:0] old_word,
		output logic        fault,
		output logic [1:0]  cause,
		output logic [31:0] rdata_out,
		output logic [31:0] new_word
	);
		logic [1:0]  off;
		logic        mis;
		logic [7:0]  lane_b;
		logic [15:0] lane_h;
		off       = addr[1:0];
		lane_b    = old_word[8*off +: 8];
		lane_h    = old_word[16*off[1] +: 16];  // half at the even offset
		mis       = 1'b0;
		rdata_out = 32'h0;
		new_word  = old_word;
		if (write) begin
			case (funct3)
				rv_lsu_pkg::store_sb: new_word[8*off +: 8] = wdata_in[7:0];
				rv_lsu_pkg::store_sh: begin
					mis = off[0];
					if (!mis) new_word[16*off[1] +: 16] = wdata_in[15:0];
				end
				rv_lsu_pkg::store_sw: begin
					mis = (off != 2'b00);
					if (!mis) new_word = wdata_in;
				end
				default: new_word = old_word;
			endcase
		end else begin
			case (funct3)
				rv_lsu_pkg::load_lb:  rdata_out = {{24{lane_b[7]}}, lane_b};
				rv_lsu_pkg::load_lbu: rdata_out = {24'h0, lane_b};
				rv_lsu_pkg::load_lh: begin
					mis       = off[0];
					rdata_out = {{16{lane_h[15]}}, lane_h};
				end
				rv_lsu_pkg::load_lhu: begin
					mis       = off[0];
					rdata_out = {16'h0, lane_h};
				end
				rv_lsu_pkg::load_lw: begin
					mis       = (off != 2'b00);
					rdata_out = old_word;
				end
				default: rdata_out = 32'h0;
			endcase
		end
		fault = mis || (addr >= 32'h400);  // memory ends at 1 KiB
		if (mis) cause = write ? rv_lsu_pkg::cause_misaligned_store
		                       : rv_lsu_pkg::cause_misaligned_load;
		else if (fault) cause = rv_lsu_pkg::cause_bus_error;
		else cause = rv_lsu_pkg::cause_none;
		if (fault) begin
			rdata_out = 32'h0;
			new_word  = old_word;
		end
	endfunction

	task automatic raise_timeout(input string what);
		abort_reason = what;
		-> abort_ev;
	endtask

	// ends the run when any wait loop runs out of time
	initial begin
		@(abort_ev);
		$display("%s", abort_reason);
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_memory();
		for (int i = 0; i < 256; i++) begin
			checks++;
			assert (mem[i] === shadow[i]) else begin
				errors++;
				$display("CHECK FAILED: mem[%0d] got %h expected %h", i, mem[i], shadow[i]);
			end
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %-24s %s (%0d errors)", name,
			(errors == err_base) ? "ok" : "bad", errors - err_base);
		err_base = errors;
	endtask

	task automatic clear_fault();
		fault_clear = 1'b1;
		@(negedge clk);
		fault_clear = 1'b0;
		check_value("fault_pending", fault_pending, 32'h0);
		check_value("fault_cause", fault_cause, rv_lsu_pkg::cause_none);
	endtask

	// drives one core request from a falling edge and waits for its response
	task automatic do_access(input logic write, input logic [2:0] funct3,
			input logic [31:0] addr, input logic [31:0] wdata_in, input logic clear);
		logic        e_fault;
		logic [1:0]  e_cause;
		logic [31:0] e_rdata;
		logic [31:0] old_word;
		logic [31:0] new_word;
		int          cnt;
		old_word = (addr < 32'h400) ? shadow[addr[9:2]] : 32'h0;
		lsu_expect(write, funct3, addr, wdata_in, old_word, e_fault, e_cause, e_rdata, new_word);
		if (addr < 32'h400) shadow[addr[9:2]] = new_word;
		exp_fault_q.push_back(e_fault);
		exp_rdata_q.push_back(e_rdata);
		exp_bus_addr = {addr[31:2], 2'b00};
		case (funct3)  // store data goes out on every lane
			rv_lsu_pkg::store_sb: exp_wdata = {4{wdata_in[7:0]}};
			rv_lsu_pkg::store_sh: exp_wdata = {2{wdata_in[15:0]}};
			default:              exp_wdata = wdata_in;
		endcase
		req_valid  = 1'b1;
		req_write  = write;
		req_funct3 = funct3;
		req_addr   = addr;
		req_wdata  = wdata_in;
		cnt = 0;
		while (!req_ready) begin
			@(negedge clk);
			cnt++;
			if (cnt > 200) raise_timeout("request was not accepted within 200 cycles");
		end
		@(negedge clk);
		req_valid = 1'b0;
		cnt = 0;
		while (!resp_valid) begin
			@(negedge clk);
			cnt++;
			if (cnt > 200) raise_timeout("no response within 200 cycles");
		end
		@(negedge clk);
		check_value("fault_pending", fault_pending, e_fault);
		check_value("req_ready", req_ready, !e_fault);
		if (e_fault) begin
			check_value("fault_cause", fault_cause, e_cause);
			check_value("fault_addr", fault_addr, addr);
			if (clear) clear_fault();
		end
	endtask

	// compares every response pulse with the oldest expectation
	always @(negedge clk) begin
		if (rst_n && resp_valid) begin
			checks++;
			assert (exp_fault_q.size() != 0) else begin
				errors++;
				$display("a response arrived with no request outstanding");
			end
			if (exp_fault_q.size() != 0) begin
				cmp_fault = exp_fault_q.pop_front();
				cmp_rdata = exp_rdata_q.pop_front();
				check_value("resp_fault", resp_fault, cmp_fault);
				check_value("resp_rdata", resp_rdata, cmp_rdata);
			end
		end
	end

	// AXI read channel of the memory model
	always begin
		@(negedge clk);
		if (rst_n && arvalid) begin
			rd_delay = $random(seed) & 3;
			repeat (rd_delay) @(negedge clk);
			arready = 1'b1;
			rd_addr = araddr;
			bus_count++;
			check_value("araddr", araddr, exp_bus_addr);
			check_value("arprot", arprot, 32'h0);
			@(negedge clk);
			arready  = 1'b0;
			rd_delay = $random(seed) & 3;
			repeat (rd_delay) @(negedge clk);
			rvalid = 1'b1;
			rresp  = (rd_addr < 32'h400) ? axi_lite_pkg::resp_okay : axi_lite_pkg::resp_slverr;
			rdata  = (rd_addr < 32'h400) ? mem[rd_addr[9:2]] : 32'hdead_beef;
			rd_wait = 0;
			while (!rready) begin
				@(negedge clk);
				rd_wait++;
				if (rd_wait > 200) raise_timeout("read data was never taken by the DUT");
			end
			@(negedge clk);
			rvalid = 1'b0;
			rresp  = axi_lite_pkg::resp_okay;
		end
	end

	// AXI write channels with AW and W accepted independently
	always begin
		@(negedge clk);
		if (rst_n && awvalid) begin
			aw_delay = $random(seed) & 3;
			w_delay  = $random(seed) & 3;
			aw_done  = 1'b0;
			w_done   = 1'b0;
			hs_wait  = 0;
			while (!(aw_done && w_done)) begin
				awready = !aw_done && (aw_delay == 0);
				wready  = !w_done && (w_delay == 0);
				aw_take = awready && awvalid;
				w_take  = wready && wvalid;
				if (aw_take) begin
					wr_addr = awaddr;
					bus_count++;
					check_value("awaddr", awaddr, exp_bus_addr);
					check_value("awprot", awprot, 32'h0);
				end
				if (w_take) begin
					wr_data = wdata;
					wr_strb = wstrb;
					check_value("wdata", wdata, exp_wdata);
				end
				@(negedge clk);
				if (aw_take) aw_done = 1'b1;
				if (w_take) w_done = 1'b1;
				if (aw_delay > 0) aw_delay--;
				if (w_delay > 0) w_delay--;
				hs_wait++;
				if (hs_wait > 200) raise_timeout("write address or data never reached the memory");
			end
			awready = 1'b0;
			wready  = 1'b0;
			if (wr_addr < 32'h400) begin
				for (bi = 0; bi < 4; bi++) begin
					if (wr_strb[bi]) mem[wr_addr[9:2]][8*bi +: 8] = wr_data[8*bi +: 8];
				end
			end
			b_delay = $random(seed) & 3;
			repeat (b_delay) @(negedge clk);
			bvalid = 1'b1;
			bresp  = (wr_addr < 32'h400) ? axi_lite_pkg::resp_okay : axi_lite_pkg::resp_slverr;
			b_wait = 0;
			while (!bready) begin
				@(negedge clk);
				b_wait++;
				if (b_wait > 200) raise_timeout("write response was never taken by the DUT");
			end
			@(negedge clk);
			bvalid = 1'b0;
			bresp  = axi_lite_pkg::resp_okay;
		end
	end

	initial begin
		rst_n       = 1'b0;
		req_valid   = 1'b0;
		req_write   = 1'b0;
		req_funct3  = 3'b000;
		req_addr    = 32'h0;
		req_wdata   = 32'h0;
		fault_clear = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i]    = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h33, i[7:0] ^ 8'hc3};
			shadow[i] = mem[i];
		end
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		do_access(1'b1, rv_lsu_pkg::store_sw, 32'h20, 32'h1122_3344, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sh, 32'h22, 32'hcafe_beef, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sb, 32'h21, 32'h0000_005a, 1'b1);
		do_access(1'b0, rv_lsu_pkg::load_lw, 32'h20, 32'h0, 1'b1);
		for (int off = 0; off < 4; off++) begin
			do_access(1'b1, rv_lsu_pkg::store_sb, 32'h30 + 5 * off, 32'hc0 + off, 1'b1);
			do_access(1'b0, rv_lsu_pkg::load_lw, 32'h30 + 4 * off, 32'h0, 1'b1);
		end
		do_access(1'b1, rv_lsu_pkg::store_sh, 32'h40, 32'h0bad_1234, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sh, 32'h46, 32'h0bad_9876, 1'b1);
		do_access(1'b0, rv_lsu_pkg::load_lw, 32'h40, 32'h0, 1'b1);
		do_access(1'b0, rv_lsu_pkg::load_lw, 32'h44, 32'h0, 1'b1);
		check_memory();
		end_test("store merge");

		do_access(1'b1, rv_lsu_pkg::store_sw, 32'h50, 32'h8f7e_6d5c, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sw, 32'h54, 32'h7f80_01fe, 1'b1);
		for (int w = 0; w < 3; w++) begin  // third word keeps its fill value
			for (int off = 0; off < 4; off++) begin
				do_access(1'b0, rv_lsu_pkg::load_lb, 32'h50 + 4 * w + off, 32'h0, 1'b1);
				do_access(1'b0, rv_lsu_pkg::load_lbu, 32'h50 + 4 * w + off, 32'h0, 1'b1);
				if (off % 2 == 0) begin
					do_access(1'b0, rv_lsu_pkg::load_lh, 32'h50 + 4 * w + off, 32'h0, 1'b1);
					do_access(1'b0, rv_lsu_pkg::load_lhu, 32'h50 + 4 * w + off, 32'h0, 1'b1);
				end
			end
		end
		end_test("load extension");

		bus_before = bus_count;
		do_access(1'b0, rv_lsu_pkg::load_lh, 32'h61, 32'h0, 1'b1);
		do_access(1'b0, rv_lsu_pkg::load_lhu, 32'h63, 32'h0, 1'b1);
		do_access(1'b0, rv_lsu_pkg::load_lw, 32'h62, 32'h0, 1'b1);
		do_access(1'b0, rv_lsu_pkg::load_lw, 32'h65, 32'h0, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sh, 32'h67, 32'h1234_5678, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sw, 32'h69, 32'h1234_5678, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sw, 32'h6e, 32'h8765_4321, 1'b1);
		check_value("bus_count", bus_count, bus_before);
		check_memory();
		end_test("misaligned");

		do_access(1'b0, rv_lsu_pkg::load_lw, 32'h82, 32'h0, 1'b0);
		req_valid  = 1'b1;  // held while the fault is pending
		req_write  = 1'b0;
		req_funct3 = rv_lsu_pkg::load_lw;
		req_addr   = 32'h84;
		repeat (8) begin
			@(negedge clk);
			checks++;
			assert (!req_ready && !resp_valid) else begin
				errors++;
				$display("a request was taken while a fault was pending");
			end
		end
		req_valid = 1'b0;
		clear_fault();
		do_access(1'b0, rv_lsu_pkg::load_lw, 32'h84, 32'h0, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sw, 32'h86, 32'h0f0f_f0f0, 1'b0);
		clear_fault();
		end_test("fault hold");

		do_access(1'b0, rv_lsu_pkg::load_lw, 32'h400, 32'h0, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sw, 32'h404, 32'hbad0_0bad, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sb, 32'h7ff, 32'h0000_0077, 1'b1);
		do_access(1'b0, rv_lsu_pkg::load_lbu, 32'h1003, 32'h0, 1'b1);
		do_access(1'b1, rv_lsu_pkg::store_sh, 32'hfffe, 32'h0000_5555, 1'b1);
		check_memory();
		end_test("bus error");

		for (int n = 0; n < 300; n++) begin
			rnd      = $random(seed);
			rnd_addr = $random(seed);
			r_write  = rnd[4];
			if (r_write) begin
				r_funct3 = {1'b0, rnd[1:0]};
				if (rnd[1:0] == 2'b11) r_funct3 = rv_lsu_pkg::store_sw;
			end else begin
				r_funct3 = rnd[2:0];  // 3, 6 and 7 are not loads
				if (r_funct3 == 3'd3 || r_funct3[2:1] == 2'b11) r_funct3 = rv_lsu_pkg::load_lw;
			end
			r_addr = {22'h0, rnd_addr[9:0]};
			if (rnd_addr[15:12] == 4'h0) r_addr[10] = 1'b1;
			do_access(r_write, r_funct3, r_addr, $random(seed), 1'b1);
		end
		check_memory();
		end_test("random");

		check_value("responses left", exp_fault_q.size(), 32'h0);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
verilog/rv_lsu_pkg.sv
verilog/axi_lite_pkg.sv
verilog/byte_lane_logic.sv
verilog/lsu_fault_status.sv
verilog/lsu_axi_master.sv
verilog/load_store_unit.sv
dv/lsu_assert.sv
dv/lsu_tb.sv

// File: Makefile
# Verilator build and run for the load/store unit testbench

SIM      ?= verilator
TOP      ?= lsu_tb
LOG      ?= sim.log
FLIST    ?= verilog.f
OUT_DIR  ?= obj_dir
SIMFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FLIST)))
BIN     := $(OUT_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OUT_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OUT_DIR) $(LOG)
